// File: hdl/nocPkg.sv
package nocPkg;

  // Field widths of one flit as it crosses the router
  localparam int flitIdW  = 3;
  localparam int lengthW  = 12;
  localparam int payloadW = 16;

  typedef logic [flitIdW-1:0]  flitIdT;
  typedef logic [lengthW-1:0]  lengthT;   // Packet length in clock cycles
  typedef logic [payloadW-1:0] payloadT;

  // Identifier carried by the first flit of a packet
  localparam flitIdT flitHead = 3'd1;

  // Local, North, East, West and South
  localparam int numPorts = 5;

endpackage

// File: hdl/arbPkg.sv
package arbPkg;

  // One-hot arbiter state, bit 0 is idle and bits 5..1 follow the grant order
  typedef enum logic [5:0] {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbStateT;

  // Bit positions in the grant vector
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

endpackage

// File: hdl/grantTimer.sv
module grantTimer
(
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::flitIdT  flitId,
  input  nocPkg::lengthT  length,
  input  logic            runTimer,
  output logic            timesUp
);

  nocPkg::lengthT limit;
  nocPkg::lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // A header flit sets the hold limit whether or not the port is granted
      if (flitId == nocPkg::flitHead)
      begin
        limit <= length;
      end

      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;   // Restart as soon as the port stops holding
      end
    end
  end

  // Expiry is seen in the same cycle the count reaches the limit
  assign timesUp = (count == limit);

endmodule

// File: hdl/outputArbiter.sv
module outputArbiter
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         LReq,
  input  logic                         NReq,
  input  logic                         EReq,
  input  logic                         WReq,
  input  logic                         SReq,
  input  nocPkg::flitIdT               LFlitId,
  input  nocPkg::flitIdT               NFlitId,
  input  nocPkg::flitIdT               EFlitId,
  input  nocPkg::flitIdT               WFlitId,
  input  nocPkg::flitIdT               SFlitId,
  input  nocPkg::lengthT               LLength,
  input  nocPkg::lengthT               NLength,
  input  nocPkg::lengthT               ELength,
  input  nocPkg::lengthT               WLength,
  input  nocPkg::lengthT               SLength,
  output logic [nocPkg::numPorts-1:0]  grant
);

  arbPkg::arbStateT               stateQ;
  arbPkg::arbStateT               nextState;
  logic [nocPkg::numPorts-1:0]    reqVec;
  logic [nocPkg::numPorts-1:0]    otherReqs;
  logic [nocPkg::numPorts-1:0]    nextGrant;
  logic [nocPkg::numPorts-1:0]    runTimer;
  logic [nocPkg::numPorts-1:0]    timesUp;
  nocPkg::flitIdT                 flitIdArr [nocPkg::numPorts];
  nocPkg::lengthT                 lengthArr [nocPkg::numPorts];
  logic                           stateLegal;
  logic                           holding;
  int                             holdIdx;

  // First requester found when scanning cyclically from index start
  function automatic logic [nocPkg::numPorts-1:0] firstReq
  (
    input logic [nocPkg::numPorts-1:0] reqs,
    input int                          start
  );
    logic [nocPkg::numPorts-1:0] pick;
    int                          idx;
    pick = '0;
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if (pick == '0 && reqs[idx])
      begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  always_comb
  begin
    reqVec[arbPkg::portL]    = LReq;
    reqVec[arbPkg::portN]    = NReq;
    reqVec[arbPkg::portE]    = EReq;
    reqVec[arbPkg::portW]    = WReq;
    reqVec[arbPkg::portS]    = SReq;
    flitIdArr[arbPkg::portL] = LFlitId;
    flitIdArr[arbPkg::portN] = NFlitId;
    flitIdArr[arbPkg::portE] = EFlitId;
    flitIdArr[arbPkg::portW] = WFlitId;
    flitIdArr[arbPkg::portS] = SFlitId;
    lengthArr[arbPkg::portL] = LLength;
    lengthArr[arbPkg::portN] = NLength;
    lengthArr[arbPkg::portE] = ELength;
    lengthArr[arbPkg::portW] = WLength;
    lengthArr[arbPkg::portS] = SLength;
  end

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : timerGen
    grantTimer timerInst
    (
      .clk      (clk),
      .rst      (rst),
      .flitId   (flitIdArr[i]),
      .length   (lengthArr[i]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  // Decode which port, if any, the current state holds
  always_comb
  begin
    stateLegal = 1'b1;
    holding    = 1'b1;
    holdIdx    = arbPkg::portL;
    case (stateQ)
      arbPkg::stIdle:  holding = 1'b0;
      arbPkg::stLocal: holdIdx = arbPkg::portL;
      arbPkg::stNorth: holdIdx = arbPkg::portN;
      arbPkg::stEast:  holdIdx = arbPkg::portE;
      arbPkg::stWest:  holdIdx = arbPkg::portW;
      arbPkg::stSouth: holdIdx = arbPkg::portS;
      default:
      begin
        stateLegal = 1'b0;
        holding    = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    runTimer  = '0;
    otherReqs = reqVec;
    otherReqs[holdIdx] = 1'b0;   // The holder never wins its own rotation
    if (!stateLegal)
    begin
      nextGrant = '0;
    end
    else if (!holding)
    begin
      nextGrant = firstReq(reqVec, arbPkg::portL);
    end
    else if (reqVec[holdIdx] && !timesUp[holdIdx])
    begin
      runTimer[holdIdx] = 1'b1;
      nextGrant = stateQ[nocPkg::numPorts:1];
    end
    else
    begin
      nextGrant = firstReq(otherReqs, (holdIdx + 1) % nocPkg::numPorts);
    end
    nextState = arbPkg::arbStateT'({nextGrant, ~|nextGrant});
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stateQ <= arbPkg::stIdle;
    end
    else
    begin
      stateQ <= nextState;
    end
  end

  assign grant = stateQ[nocPkg::numPorts:1];   // Drop the idle bit

endmodule

// File: hdl/flitSwitch.sv
module flitSwitch
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic [nocPkg::numPorts-1:0]  grant,
  input  nocPkg::flitIdT               LFlitId,
  input  nocPkg::flitIdT               NFlitId,
  input  nocPkg::flitIdT               EFlitId,
  input  nocPkg::flitIdT               WFlitId,
  input  nocPkg::flitIdT               SFlitId,
  input  nocPkg::lengthT               LLength,
  input  nocPkg::lengthT               NLength,
  input  nocPkg::lengthT               ELength,
  input  nocPkg::lengthT               WLength,
  input  nocPkg::lengthT               SLength,
  input  nocPkg::payloadT              LData,
  input  nocPkg::payloadT              NData,
  input  nocPkg::payloadT              EData,
  input  nocPkg::payloadT              WData,
  input  nocPkg::payloadT              SData,
  output logic                         outValid,
  output nocPkg::flitIdT               outFlitId,
  output nocPkg::lengthT               outLength,
  output nocPkg::payloadT              outData
);

  nocPkg::flitIdT   idArr   [nocPkg::numPorts];
  nocPkg::lengthT   lenArr  [nocPkg::numPorts];
  nocPkg::payloadT  dataArr [nocPkg::numPorts];
  nocPkg::flitIdT   selId;
  nocPkg::lengthT   selLength;
  nocPkg::payloadT  selData;

  always_comb
  begin
    idArr[arbPkg::portL]   = LFlitId;
    idArr[arbPkg::portN]   = NFlitId;
    idArr[arbPkg::portE]   = EFlitId;
    idArr[arbPkg::portW]   = WFlitId;
    idArr[arbPkg::portS]   = SFlitId;
    lenArr[arbPkg::portL]  = LLength;
    lenArr[arbPkg::portN]  = NLength;
    lenArr[arbPkg::portE]  = ELength;
    lenArr[arbPkg::portW]  = WLength;
    lenArr[arbPkg::portS]  = SLength;
    dataArr[arbPkg::portL] = LData;
    dataArr[arbPkg::portN] = NData;
    dataArr[arbPkg::portE] = EData;
    dataArr[arbPkg::portW] = WData;
    dataArr[arbPkg::portS] = SData;
  end

  // AND-OR mux, the grant is one-hot or zero
  always_comb
  begin
    selId     = '0;
    selLength = '0;
    selData   = '0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i])
      begin
        selId     = selId | idArr[i];
        selLength = selLength | lenArr[i];
        selData   = selData | dataArr[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |grant;
    end
    outFlitId <= selId;
    outLength <= selLength;
    outData   <= selData;
  end

endmodule

// File: hdl/routerOutputPort.sv
module routerOutputPort
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         LReq,
  input  nocPkg::flitIdT               LFlitId,
  input  nocPkg::lengthT               LLength,
  input  nocPkg::payloadT              LData,
  input  logic                         NReq,
  input  nocPkg::flitIdT               NFlitId,
  input  nocPkg::lengthT               NLength,
  input  nocPkg::payloadT              NData,
  input  logic                         EReq,
  input  nocPkg::flitIdT               EFlitId,
  input  nocPkg::lengthT               ELength,
  input  nocPkg::payloadT              EData,
  input  logic                         WReq,
  input  nocPkg::flitIdT               WFlitId,
  input  nocPkg::lengthT               WLength,
  input  nocPkg::payloadT              WData,
  input  logic                         SReq,
  input  nocPkg::flitIdT               SFlitId,
  input  nocPkg::lengthT               SLength,
  input  nocPkg::payloadT              SData,
  output logic [nocPkg::numPorts-1:0]  grant,
  output logic                         outValid,
  output nocPkg::flitIdT               outFlitId,
  output nocPkg::lengthT               outLength,
  output nocPkg::payloadT              outData
);

  outputArbiter outputArbiter_i
  (
    .clk     (clk),
    .rst     (rst),
    .LReq    (LReq),
    .NReq    (NReq),
    .EReq    (EReq),
    .WReq    (WReq),
    .SReq    (SReq),
    .LFlitId (LFlitId),
    .NFlitId (NFlitId),
    .EFlitId (EFlitId),
    .WFlitId (WFlitId),
    .SFlitId (SFlitId),
    .LLength (LLength),
    .NLength (NLength),
    .ELength (ELength),
    .WLength (WLength),
    .SLength (SLength),
    .grant   (grant)
  );

  // Forwards the flit of the port granted in the previous cycle
  flitSwitch flitSwitch_i
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .LFlitId   (LFlitId),
    .NFlitId   (NFlitId),
    .EFlitId   (EFlitId),
    .WFlitId   (WFlitId),
    .SFlitId   (SFlitId),
    .LLength   (LLength),
    .NLength   (NLength),
    .ELength   (ELength),
    .WLength   (WLength),
    .SLength   (SLength),
    .LData     (LData),
    .NData     (NData),
    .EData     (EData),
    .WData     (WData),
    .SData     (SData),
    .outValid  (outValid),
    .outFlitId (outFlitId),
    .outLength (outLength),
    .outData   (outData)
  );

endmodule

// File: verification/outputArbiter_checker.sv
module outputArbiter_checker
(
  input  logic                         clk,
  input  logic                         rst,
  input  arbPkg::arbStateT             stateQ,
  input  logic [nocPkg::numPorts-1:0]  grant,
  input  logic [nocPkg::numPorts-1:0]  runTimer,
  input  logic [nocPkg::numPorts-1:0]  timesUp
);

  logic errorSeen = 1'b0;

  // Every legal state has exactly one bit set
  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(stateQ))
    else
    begin
      $error("error at %0t: stateQ expected one-hot, actual %b", $time, stateQ);
      errorSeen = 1'b1;
    end

  resetToIdle: assert property (@(posedge clk) rst |=> stateQ == arbPkg::stIdle)
    else
    begin
      $error("error at %0t: stateQ expected stIdle after reset, actual %b", $time, stateQ);
      errorSeen = 1'b1;
    end

  // Only the holding port may run its timer
  timerOnlyHolder: assert property (@(posedge clk) disable iff (rst)
    $onehot0(runTimer) && (runTimer & ~grant) == '0)
    else
    begin
      $error("error at %0t: runTimer expected within grant %b, actual %b", $time,
             grant, runTimer);
      errorSeen = 1'b1;
    end

  expiryReleases: assert property (@(posedge clk) disable iff (rst)
    (grant & timesUp) != '0 |=> (grant & $past(grant)) == '0)
    else
    begin
      $error("error at %0t: grant kept after timer expiry, grant %b", $time, grant);
      errorSeen = 1'b1;
    end

  // Covers limit 0 too, where timesUp is already high on the first held cycle
  holdNeedsTimer: assert property (@(posedge clk) disable iff (rst)
    (grant != '0 && (grant & runTimer) == '0) |=> (grant & $past(grant)) == '0)
    else
    begin
      $error("error at %0t: grant kept without a running timer, grant %b", $time, grant);
      errorSeen = 1'b1;
    end

endmodule

bind outputArbiter outputArbiter_checker arbChecker_i
(
  .clk      (clk),
  .rst      (rst),
  .stateQ   (stateQ),
  .grant    (grant),
  .runTimer (runTimer),
  .timesUp  (timesUp)
);

// File: verification/routerOutputPort_tb.sv
module routerOutputPort_tb;

  localparam int resetCycles  = 4;
  localparam int randomCycles = 400;
  localparam int drainCycles  = 10;
  localparam int clkPeriod    = 100;
  localparam int nP           = nocPkg::numPorts;

  logic                   clk;
  logic                   rst;
  logic                   req    [nP];
  nocPkg::flitIdT         flitId [nP];
  nocPkg::lengthT         length [nP];
  nocPkg::payloadT        data   [nP];
  logic [nP-1:0]          grant;
  logic                   outValid;
  nocPkg::flitIdT         outFlitId;
  nocPkg::lengthT         outLength;
  nocPkg::payloadT        outData;

  int                     expHolder;   // Port index, -1 while idle
  nocPkg::lengthT         expCount [nP];
  nocPkg::lengthT         expLimit [nP];
  logic                   expValid;
  nocPkg::flitIdT         expFlitId;
  nocPkg::lengthT         expLength;
  nocPkg::payloadT        expData;
  int                     heldPort;
  int                     holdLen;
  int                     runLimit;
  logic                   runClean;   // Limit unchanged since the hold began
  logic                   draining = 1'b0;
  logic                   failed   = 1'b0;
  logic                   checkerFailed;
  integer                 seed;

  routerOutputPort routerOutputPort_i
  (
    .clk (clk), .rst (rst),
    .LReq (req[arbPkg::portL]), .LFlitId (flitId[arbPkg::portL]),
    .LLength (length[arbPkg::portL]), .LData (data[arbPkg::portL]),
    .NReq (req[arbPkg::portN]), .NFlitId (flitId[arbPkg::portN]),
    .NLength (length[arbPkg::portN]), .NData (data[arbPkg::portN]),
    .EReq (req[arbPkg::portE]), .EFlitId (flitId[arbPkg::portE]),
    .ELength (length[arbPkg::portE]), .EData (data[arbPkg::portE]),
    .WReq (req[arbPkg::portW]), .WFlitId (flitId[arbPkg::portW]),
    .WLength (length[arbPkg::portW]), .WData (data[arbPkg::portW]),
    .SReq (req[arbPkg::portS]), .SFlitId (flitId[arbPkg::portS]),
    .SLength (length[arbPkg::portS]), .SData (data[arbPkg::portS]),
    .grant (grant), .outValid (outValid), .outFlitId (outFlitId),
    .outLength (outLength), .outData (outData)
  );

  assign checkerFailed = routerOutputPort_i.outputArbiter_i.arbChecker_i.errorSeen;

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Scans span ports cyclically from first and returns the first requester
  function automatic int pickRequester(input logic [nP-1:0] reqs, input int first, input int span);
    for (int k = 0; k < span; k++)
      if (reqs[(first + k) % nP])
        return (first + k) % nP;
    return -1;
  endfunction

  // Reference model of the arbitration and timer rules
  always @(posedge clk)
  begin : refModel
    logic [nP-1:0] reqs;
    int            nextHolder;
    logic          keep;
    for (int p = 0; p < nP; p++)
      reqs[p] = req[p];
    keep = 1'b0;
    if (expHolder < 0)
      nextHolder = pickRequester(reqs, 0, nP);
    else if (reqs[expHolder] && expCount[expHolder] != expLimit[expHolder])
    begin
      nextHolder = expHolder;
      keep       = 1'b1;
    end
    else
      nextHolder = pickRequester(reqs, (expHolder + 1) % nP, nP - 1);
    expValid = (expHolder >= 0);
    if (expValid)
    begin
      expFlitId = flitId[expHolder];
      expLength = length[expHolder];
      expData   = data[expHolder];
    end
    for (int p = 0; p < nP; p++)
    begin
      expCount[p] = (keep && p == expHolder) ? expCount[p] + 1'b1 : '0;
      if (flitId[p] == nocPkg::flitHead)
        expLimit[p] = length[p];
    end
    expHolder = nextHolder;
    if (rst)
    begin
      expHolder = -1;
      expValid  = 1'b0;
      for (int p = 0; p < nP; p++)
      begin
        expCount[p] = '0;
        expLimit[p] = '0;
      end
    end
  end

  task automatic checkOutputs;
    logic [nP-1:0] expGrant;
    int            grantIdx;
    expGrant = (expHolder < 0) ? '0 : nP'(1) << expHolder;
    assert ($onehot0(grant)) else begin
      $error("error at %0t: grant expected one-hot or zero, actual %b", $time, grant);
      failed = 1'b1;
    end
    assert (grant === expGrant) else begin
      $error("error at %0t: grant expected %b actual %b", $time, expGrant, grant);
      failed = 1'b1;
    end
    assert (outValid === expValid) else begin
      $error("error at %0t: outValid expected %b actual %b", $time, expValid, outValid);
      failed = 1'b1;
    end
    assert (!expValid || (outFlitId === expFlitId && outLength === expLength
                          && outData === expData)) else begin
      $error("error at %0t: outFlitId/outLength/outData expected %h/%h/%h actual %h/%h/%h",
             $time, expFlitId, expLength, expData, outFlitId, outLength, outData);
      failed = 1'b1;
    end
    assert (!draining || grant == '0) else begin
      $error("error at %0t: grant expected 0 while drained, actual %b", $time, grant);
      failed = 1'b1;
    end
    // Hold runs are measured on the DUT grant itself
    grantIdx = -1;
    for (int p = 0; p < nP; p++)
      if (grant[p])
        grantIdx = p;
    if (grantIdx < 0)
      heldPort = -1;
    else if (grantIdx != heldPort)
    begin
      heldPort = grantIdx;
      holdLen  = 1;
      runLimit = expLimit[grantIdx];
      runClean = 1'b1;
    end
    else
    begin
      holdLen++;
      if (expLimit[grantIdx] != runLimit)
        runClean = 1'b0;   // A header during the hold moves the bound
    end
    assert (heldPort < 0 || !runClean || holdLen <= runLimit + 1) else begin
      $error("error at %0t: hold length of port %0d expected at most %0d actual %0d",
             $time, heldPort, runLimit + 1, holdLen);
      failed = 1'b1;
    end
  endtask

  task automatic driveRandomInputs;
    logic [31:0] r;
    for (int p = 0; p < nP; p++)
    begin
      r = $random(seed);
      if (r[1:0] == 2'b00)
        req[p] = ~req[p];
      if (r[3:2] == 2'b00)
      begin
        flitId[p] = nocPkg::flitHead;
        length[p] = nocPkg::lengthT'(r[31:8] % 7);   // Short limits so timeouts are frequent
      end
      else
      begin
        flitId[p] = (r[6:4] == nocPkg::flitHead) ? 3'd0 : r[6:4];
        length[p] = r[19:8];
      end
      data[p] = nocPkg::payloadT'($random(seed));
    end
  endtask

  initial
  begin
    wait (failed || checkerFailed);
    $display("Testbench failed");
    $fatal(1, "stopped at the first failed check");
  end

  initial
  begin
    #((resetCycles + randomCycles + drainCycles + 50) * clkPeriod);
    $display("Timeout: the test sequence did not finish in the expected time");
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    seed     = 21;
    heldPort = -1;
    holdLen  = 0;
    runLimit = 0;
    runClean = 1'b0;
    rst      = 1'b1;
    for (int p = 0; p < nP; p++)
    begin
      req[p]    = 1'b0;
      flitId[p] = '0;
      length[p] = '0;
      data[p]   = '0;
    end
    repeat (resetCycles) @(negedge clk);
    assert (grant == '0 && outValid == 1'b0) else begin
      $error("error at %0t: grant/outValid expected 0/0 after reset, actual %b/%b",
             $time, grant, outValid);
      failed = 1'b1;
    end
    rst = 1'b0;
    driveRandomInputs();
    repeat (randomCycles)
    begin
      @(negedge clk);
      checkOutputs();
      driveRandomInputs();
    end
    repeat (drainCycles)
    begin
      @(negedge clk);
      checkOutputs();
      for (int p = 0; p < nP; p++)
        req[p] = 1'b0;
      draining = 1'b1;
    end
    if (failed || checkerFailed)
    begin
      $display("Testbench failed");
      $fatal(1, "checks failed");
    end
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: sources.f
hdl/nocPkg.sv
hdl/arbPkg.sv
hdl/grantTimer.sv
hdl/outputArbiter.sv
hdl/flitSwitch.sv
hdl/routerOutputPort.sv
verification/outputArbiter_checker.sv
verification/routerOutputPort_tb.sv
